/* hw/md_loader_pkg.sv */
`default_nettype none
////////////////////////////////////////
// Cartridge loader shared definitions
// Host download beat, cartridge state, region setup,
// cheat records and backup RAM sector requests
////////////////////////////////////////

package md_loader_pkg;

	// Download indices, matched against index bits 4:0
	localparam logic [4:0] IDX_CART_MD  = 5'd1;
	localparam logic [4:0] IDX_CART_SMS = 5'd2;

	// Cartridge header byte addresses
	localparam logic [24:0] HDR_REGION_ADDR  = 25'h1F0;
	localparam logic [24:0] HDR_REGION2_ADDR = 25'h1F2;
	localparam logic [24:0] HDR_END_ADDR     = 25'h200;

	// PS/2 scan codes for F1 to F3
	localparam logic [8:0] KEY_F1 = 9'h005;
	localparam logic [8:0] KEY_F2 = 9'h006;
	localparam logic [8:0] KEY_F3 = 9'h004;

	localparam int SAVE_SECTORS = 128;
	localparam int CHEAT_WORDS  = 8;

	////////////////////////////////////////
	// Host side
	////////////////////////////////////////

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
	} ioctl_bus_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic [6:0] lba;
		logic       rd;
		logic       wr;
	} sd_req_t;

	////////////////////////////////////////
	// Cartridge and region
	////////////////////////////////////////

	typedef struct packed {
		logic active;
		logic ms;
		logic hdr_ready;
		logic hdr_j;
		logic hdr_u;
		logic hdr_e;
	} cart_info_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// Search order of the header flags
	typedef enum logic [1:0] {
		PRIO_UEJ = 2'd0,
		PRIO_EUJ = 2'd1,
		PRIO_UJE = 2'd2,
		PRIO_JUE = 2'd3
	} region_prio_e;

	typedef enum logic [1:0] {
		AUTO_HEADER   = 2'd0,
		AUTO_FILE_EXT = 2'd1,
		AUTO_DISABLED = 2'd2
	} auto_region_e;

	typedef struct packed {
		auto_region_e mode;
		region_prio_e prio;
	} region_cfg_t;

	// One cheat record as stored by the matching engine
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

/* hw/cart_header_scan.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Cartridge download decode and header scan
// Flags MD/SMS images and collects the region
// letters found in the cartridge header
////////////////////////////////////////

module cart_header_scan import md_loader_pkg::*; (
	input  wire        clk_sys,
	input  wire        sys_reset,
	input  ioctl_bus_t ioctl_i,
	output cart_info_t cart_o
);

	logic       cart_dl;
	logic       cart_dl_d;
	logic       dl_start;
	logic       dl_end;
	logic       hdr_wr;
	logic       ms_q;
	logic       hdr_ready_q;
	logic [2:0] hdr_flags;
	logic [2:0] hdr_flags_nxt;
	logic [2:0] lo_letter;
	logic [2:0] hi_letter;
	logic [7:0] lo_byte;
	logic [3:0] hex_val;

	// Letter to {j,u,e}
	function automatic logic [2:0] letter_flags(input logic [7:0] ch);
		logic [2:0] f;
		f = 3'b000;
		case (ch)
			"J": f = 3'b100;
			"U": f = 3'b010;
			"E": f = 3'b001;
			default: f = 3'b000;
		endcase
		return f;
	endfunction

	assign cart_dl  = ioctl_i.download &
		(ioctl_i.index[4:0] == IDX_CART_MD || ioctl_i.index[4:0] == IDX_CART_SMS);
	assign dl_start = cart_dl & ~cart_dl_d;
	assign dl_end   = ~cart_dl & cart_dl_d;
	assign hdr_wr   = cart_dl & ioctl_i.wr;

	assign lo_byte   = ioctl_i.data[7:0];
	assign hex_val   = lo_byte[3:0] - 4'd7;
	assign lo_letter = letter_flags(lo_byte);
	assign hi_letter = letter_flags(ioctl_i.data[15:8]);

	always_comb begin
		hdr_flags_nxt = hdr_flags;
		if (dl_start)
			hdr_flags_nxt = 3'b000;
		if (hdr_wr && ioctl_i.addr == HDR_REGION_ADDR) begin
			// Low byte may also hold a hex region mask (bit0 J, bit2 U, bit3 E)
			if (|lo_letter)
				hdr_flags_nxt = hdr_flags_nxt | lo_letter;
			else if (lo_byte >= "0" && lo_byte <= "9")
				hdr_flags_nxt = {lo_byte[0], lo_byte[2], lo_byte[3]};
			else if (lo_byte >= "A" && lo_byte <= "F")
				hdr_flags_nxt = {hex_val[0], hex_val[2], hex_val[3]};
			hdr_flags_nxt = hdr_flags_nxt | hi_letter;
		end
		if (hdr_wr && ioctl_i.addr == HDR_REGION2_ADDR)
			hdr_flags_nxt = hdr_flags_nxt | lo_letter;
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cart_dl_d   <= 1'b0;
			ms_q        <= 1'b0;
			hdr_ready_q <= 1'b0;
			hdr_flags   <= 3'b000;
		end else begin
			cart_dl_d <= cart_dl;
			hdr_flags <= hdr_flags_nxt;
			if (dl_start)
				ms_q <= (ioctl_i.index[4:0] == IDX_CART_SMS);
			if (dl_end)
				hdr_ready_q <= 1'b0;
			if (hdr_wr && ioctl_i.addr == HDR_END_ADDR)
				hdr_ready_q <= 1'b1;
		end
	end

	assign cart_o = '{active: cart_dl, ms: ms_q, hdr_ready: hdr_ready_q,
		hdr_j: hdr_flags[2], hdr_u: hdr_flags[1], hdr_e: hdr_flags[0]};

endmodule

`default_nettype wire

/* hw/region_select.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Console region selection
// Header flags, file index or F1..F3 keys
////////////////////////////////////////

module region_select import md_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         sys_reset,
	input  cart_info_t  cart_i,
	input  wire  [7:0]  ioctl_index_i,
	input  region_cfg_t region_cfg_i,
	input  ps2_key_t    key_i,
	output region_e     region_o,
	output logic        region_set_o
);

	logic    ready_d;
	logic    toggle_d;
	logic    ready_rise;
	logic    ready_fall;
	logic    key_event;
	region_e auto_region;
	region_e region_q;
	logic    set_q;

	assign ready_rise = cart_i.hdr_ready & ~ready_d;
	assign ready_fall = ~cart_i.hdr_ready & ready_d;
	assign key_event  = key_i.toggle != toggle_d;

	// First flag present in the configured order
	always_comb begin
		auto_region = REGION_US;
		case (region_cfg_i.prio)
			PRIO_UEJ: begin
				if (cart_i.hdr_u)      auto_region = REGION_US;
				else if (cart_i.hdr_e) auto_region = REGION_EU;
				else if (cart_i.hdr_j) auto_region = REGION_JP;
				else                   auto_region = REGION_US;
			end
			PRIO_EUJ: begin
				if (cart_i.hdr_e)      auto_region = REGION_EU;
				else if (cart_i.hdr_u) auto_region = REGION_US;
				else if (cart_i.hdr_j) auto_region = REGION_JP;
				else                   auto_region = REGION_EU;
			end
			PRIO_UJE: begin
				if (cart_i.hdr_u)      auto_region = REGION_US;
				else if (cart_i.hdr_j) auto_region = REGION_JP;
				else if (cart_i.hdr_e) auto_region = REGION_EU;
				else                   auto_region = REGION_US;
			end
			PRIO_JUE: begin
				if (cart_i.hdr_j)      auto_region = REGION_JP;
				else if (cart_i.hdr_u) auto_region = REGION_US;
				else if (cart_i.hdr_e) auto_region = REGION_EU;
				else                   auto_region = REGION_JP;
			end
			default: auto_region = REGION_US;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			ready_d  <= 1'b0;
			toggle_d <= 1'b0;
			region_q <= REGION_JP;
			set_q    <= 1'b0;
		end else begin
			ready_d  <= cart_i.hdr_ready;
			toggle_d <= key_i.toggle;

			if (key_event) begin
				case (key_i.code)
					KEY_F1: begin
						region_q <= REGION_JP;
						set_q    <= key_i.pressed;
					end
					KEY_F2: begin
						region_q <= REGION_US;
						set_q    <= key_i.pressed;
					end
					KEY_F3: begin
						region_q <= REGION_EU;
						set_q    <= key_i.pressed;
					end
					default: ;
				endcase
			end

			// Master System images carry no MD header
			if (ready_rise && !cart_i.ms && region_cfg_i.mode != AUTO_DISABLED) begin
				if (region_cfg_i.mode == AUTO_HEADER) begin
					region_q <= auto_region;
					set_q    <= 1'b1;
				end else begin
					region_q <= region_e'(ioctl_index_i[7:6]);
					set_q    <= |ioctl_index_i;
				end
			end

			if (ready_fall)
				set_q <= 1'b0;
		end
	end

	assign region_o     = region_q;
	assign region_set_o = set_q;

endmodule

`default_nettype wire

/* hw/cheat_code_loader.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Cheat file loader
// Packs 16-bit download words into cheat records
////////////////////////////////////////

module cheat_code_loader import md_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         sys_reset,
	input  ioctl_bus_t  ioctl_i,
	input  cart_info_t  cart_i,
	output cheat_code_t cheat_o,
	output logic        cheat_valid_o
);

	// Byte offset of the last word in a record
	localparam logic [3:0] LAST_OFS = 4'((CHEAT_WORDS - 1) * 2);

	logic        code_wr;
	cheat_code_t cheat_q;
	logic        valid_q;

	assign code_wr = ioctl_i.download & (&ioctl_i.index) & ioctl_i.wr;

	// Record words arrive low half first
	always_ff @(posedge clk_sys) begin
		if (cart_i.active) begin
			cheat_q <= '0;
		end else if (code_wr) begin
			case (ioctl_i.addr[3:0])
				4'd0:  cheat_q.flags[15:0]    <= ioctl_i.data;
				4'd2:  cheat_q.flags[31:16]   <= ioctl_i.data;
				4'd4:  cheat_q.addr[15:0]     <= ioctl_i.data;
				4'd6:  cheat_q.addr[31:16]    <= ioctl_i.data;
				4'd8:  cheat_q.compare[15:0]  <= ioctl_i.data;
				4'd10: cheat_q.compare[31:16] <= ioctl_i.data;
				4'd12: cheat_q.replace[15:0]  <= ioctl_i.data;
				4'd14: cheat_q.replace[31:16] <= ioctl_i.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset)
			valid_q <= 1'b0;
		else
			valid_q <= code_wr && !cart_i.active && ioctl_i.addr[3:0] == LAST_OFS;
	end

	assign cheat_o       = cheat_q;
	assign cheat_valid_o = valid_q;

endmodule

`default_nettype wire

/* hw/backup_ram_seq.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Backup RAM save/load sequencer
// Walks all save sectors through the host
// request/ack handshake and tracks autosave
////////////////////////////////////////

module backup_ram_seq import md_loader_pkg::*; (
	input  wire        clk_sys,
	input  wire        sys_reset,
	input  cart_info_t cart_i,
	input  wire        img_mounted_i,
	input  wire        img_readonly_i,
	input  wire        img_size_nz_i,
	input  wire        bk_load_i,
	input  wire        bk_save_i,
	input  wire        autosave_i,
	input  wire        osd_status_i,
	input  wire        bk_change_i,
	input  wire        sd_ack_i,
	output sd_req_t    sd_req_o,
	output logic       bk_loading_o,
	output logic       bk_busy_o,
	output logic       sav_pending_o
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQ,
		SEQ_ACK
	} seq_state_e;

	localparam logic [6:0] LAST_LBA = 7'(SAVE_SECTORS - 1);

	seq_state_e state;
	logic       bk_ena;
	logic       pending;
	logic       loading;
	logic [6:0] lba_q;
	logic       rd_q;
	logic       wr_q;
	logic       active_d;
	logic       change_d;
	logic       load_d;
	logic       save_d;
	logic       ack_d;
	logic       save_req;
	logic       start_load;
	logic       start_save;
	logic       dl_done;

	// Autosave fires once the OSD is opened
	assign save_req   = bk_save_i | (pending & osd_status_i & autosave_i);
	assign dl_done    = active_d & ~cart_i.active & img_size_nz_i;
	assign start_load = dl_done | (bk_load_i & ~load_d);
	assign start_save = save_req & ~save_d;

	////////////////////////////////////////
	// Enable and pending flag
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			active_d <= 1'b0;
			change_d <= 1'b0;
			bk_ena   <= 1'b0;
			pending  <= 1'b0;
		end else begin
			active_d <= cart_i.active;
			change_d <= bk_change_i;
			if (cart_i.active && !active_d)
				bk_ena <= 1'b0;
			// Save image is mounted while the cartridge streams in
			if (cart_i.active && img_mounted_i && !img_readonly_i)
				bk_ena <= 1'b1;
			if (bk_change_i && !change_d && !osd_status_i)
				pending <= 1'b1;
			else if (state != SEQ_IDLE)
				pending <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Sector sequencer
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			state   <= SEQ_IDLE;
			loading <= 1'b0;
			lba_q   <= '0;
			rd_q    <= 1'b0;
			wr_q    <= 1'b0;
			load_d  <= 1'b0;
			save_d  <= 1'b0;
			ack_d   <= 1'b0;
		end else begin
			load_d <= bk_load_i;
			save_d <= save_req;
			ack_d  <= sd_ack_i;
			case (state)
				SEQ_IDLE: begin
					if (bk_ena && (start_load || start_save)) begin
						state   <= SEQ_REQ;
						loading <= start_load;
						lba_q   <= '0;
						rd_q    <= start_load;
						wr_q    <= ~start_load;
					end
				end
				SEQ_REQ: begin
					if (sd_ack_i && !ack_d) begin
						rd_q  <= 1'b0;
						wr_q  <= 1'b0;
						state <= SEQ_ACK;
					end
				end
				SEQ_ACK: begin
					if (!sd_ack_i && ack_d) begin
						if (lba_q == LAST_LBA) begin
							state   <= SEQ_IDLE;
							loading <= 1'b0;
						end else begin
							state <= SEQ_REQ;
							lba_q <= lba_q + 7'd1;
							rd_q  <= loading;
							wr_q  <= ~loading;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	assign sd_req_o      = '{lba: lba_q, rd: rd_q, wr: wr_q};
	assign bk_loading_o  = loading;
	assign bk_busy_o     = state != SEQ_IDLE;
	assign sav_pending_o = pending;

endmodule

`default_nettype wire

/* hw/md_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Mega Drive cartridge loader top level
// Header scan, region choice, cheats, backup RAM
////////////////////////////////////////

module md_loader_top import md_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         sys_reset,
	input  ioctl_bus_t  ioctl_i,
	input  ps2_key_t    key_i,
	input  region_cfg_t region_cfg_i,
	input  wire         img_mounted_i,
	input  wire         img_readonly_i,
	input  wire         img_size_nz_i,
	input  wire         bk_load_i,
	input  wire         bk_save_i,
	input  wire         autosave_i,
	input  wire         osd_status_i,
	input  wire         bk_change_i,
	input  wire         sd_ack_i,
	output region_e     region_o,
	output logic        region_set_o,
	output cheat_code_t cheat_o,
	output logic        cheat_valid_o,
	output sd_req_t     sd_req_o,
	output logic        bk_loading_o,
	output logic        bk_busy_o,
	output logic        sav_pending_o,
	output cart_info_t  cart_o
);

	// Cartridge state fans out to the other blocks
	cart_header_scan cart_header_scan_inst (
		.clk_sys   (clk_sys),
		.sys_reset (sys_reset),
		.ioctl_i   (ioctl_i),
		.cart_o    (cart_o)
	);

	region_select region_select_inst (
		.clk_sys       (clk_sys),
		.sys_reset     (sys_reset),
		.cart_i        (cart_o),
		.ioctl_index_i (ioctl_i.index),
		.region_cfg_i  (region_cfg_i),
		.key_i         (key_i),
		.region_o      (region_o),
		.region_set_o  (region_set_o)
	);

	cheat_code_loader cheat_code_loader_inst (
		.clk_sys       (clk_sys),
		.sys_reset     (sys_reset),
		.ioctl_i       (ioctl_i),
		.cart_i        (cart_o),
		.cheat_o       (cheat_o),
		.cheat_valid_o (cheat_valid_o)
	);

	backup_ram_seq backup_ram_seq_inst (
		.clk_sys        (clk_sys),
		.sys_reset      (sys_reset),
		.cart_i         (cart_o),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_nz_i  (img_size_nz_i),
		.bk_load_i      (bk_load_i),
		.bk_save_i      (bk_save_i),
		.autosave_i     (autosave_i),
		.osd_status_i   (osd_status_i),
		.bk_change_i    (bk_change_i),
		.sd_ack_i       (sd_ack_i),
		.sd_req_o       (sd_req_o),
		.bk_loading_o   (bk_loading_o),
		.bk_busy_o      (bk_busy_o),
		.sav_pending_o  (sav_pending_o)
	);

endmodule

`default_nettype wire

/* test/tb_md_loader.sv */
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Cartridge loader testbench
// Directed tests for header scan, region choice,
// cheat records and backup RAM sequencing
////////////////////////////////////////

module tb_md_loader import md_loader_pkg::*; ();

	localparam int CYCLE_LIMIT = 5000;

	// Expected region per priority setting, indexed by region_prio_e
	localparam region_e EXP_ALL [4] = '{REGION_US, REGION_EU, REGION_US, REGION_JP};
	localparam region_e EXP_JE [4] = '{REGION_EU, REGION_EU, REGION_JP, REGION_JP};
	localparam region_e EXP_NONE [4] = '{REGION_US, REGION_EU, REGION_US, REGION_JP};

	logic        clk_sys;
	logic        sys_reset;
	ioctl_bus_t  ioctl;
	ps2_key_t    key;
	region_cfg_t region_cfg;
	logic        img_mounted;
	logic        img_readonly;
	logic        img_size_nz;
	logic        bk_load;
	logic        bk_save;
	logic        autosave;
	logic        osd_status;
	logic        bk_change;
	logic        sd_ack;
	region_e     region;
	logic        region_set;
	cheat_code_t cheat;
	logic        cheat_valid;
	sd_req_t     sd_req;
	logic        bk_loading;
	logic        bk_busy;
	logic        sav_pending;
	cart_info_t  cart;
	int          cycles = 0;
	int          seed;

	md_loader_top md_loader_top_inst (
		.clk_sys (clk_sys), .sys_reset (sys_reset), .ioctl_i (ioctl), .key_i (key),
		.region_cfg_i (region_cfg), .img_mounted_i (img_mounted),
		.img_readonly_i (img_readonly), .img_size_nz_i (img_size_nz),
		.bk_load_i (bk_load), .bk_save_i (bk_save), .autosave_i (autosave),
		.osd_status_i (osd_status), .bk_change_i (bk_change), .sd_ack_i (sd_ack),
		.region_o (region), .region_set_o (region_set), .cheat_o (cheat),
		.cheat_valid_o (cheat_valid), .sd_req_o (sd_req), .bk_loading_o (bk_loading),
		.bk_busy_o (bk_busy), .sav_pending_o (sav_pending), .cart_o (cart)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic check_region(input region_e exp, input logic exp_set);
		if (region !== exp || region_set !== exp_set) begin
			$display("[ERROR] region_o/region_set_o: got %h/%h expected %h/%h",
				region, region_set, exp, exp_set);
			abort_run();
		end
	endtask

	task automatic check_cheat(input cheat_code_t exp);
		if (cheat !== exp) begin
			$display("[ERROR] cheat_o: got %h expected %h", cheat, exp);
			abort_run();
		end
	endtask

	task automatic check_sd(input sd_req_t exp);
		if (sd_req !== exp) begin
			$display("[ERROR] sd_req_o: got %h expected %h", sd_req, exp);
			abort_run();
		end
	endtask

	task automatic check_cart(input cart_info_t exp);
		if (cart !== exp) begin
			$display("[ERROR] cart_o: got %h expected %h", cart, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// Cartridge state once a download has ended, header flags as {j,u,e}
	function automatic cart_info_t cart_after(input logic ms, input logic [2:0] jue);
		cart_info_t c;
		c       = '0;
		c.ms    = ms;
		c.hdr_j = jue[2];
		c.hdr_u = jue[1];
		c.hdr_e = jue[0];
		return c;
	endfunction

	////////////////////////////////////////
	// Host models
	////////////////////////////////////////

	task automatic start_download(input logic [7:0] idx);
		ioctl.download = 1'b1;
		ioctl.index    = idx;
		@(negedge clk_sys);
	endtask

	// One write beat per cycle
	task automatic write_beat(input logic [24:0] addr, input logic [15:0] data);
		ioctl.wr   = 1'b1;
		ioctl.addr = addr;
		ioctl.data = data;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
	endtask

	task automatic end_download();
		ioctl.download = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic run_header(input logic [7:0] idx, input logic [15:0] w1f0,
			input logic [15:0] w1f2, input region_e exp, input logic exp_set);
		start_download(idx);
		write_beat(HDR_REGION_ADDR, w1f0);
		write_beat(HDR_REGION2_ADDR, w1f2);
		write_beat(HDR_END_ADDR, 16'h0000);
		// Region lands one edge after hdr_ready
		@(negedge clk_sys);
		check_region(exp, exp_set);
		check_flag("cart_o.active", cart.active, 1'b1);
		check_flag("cart_o.hdr_ready", cart.hdr_ready, 1'b1);
		end_download();
		check_region(exp, 1'b0);
	endtask

	task automatic ack_sector(input sd_req_t dropped);
		int delay;
		delay = ($unsigned($random(seed)) % 4) + 1;
		repeat (delay) @(negedge clk_sys);
		sd_ack = 1'b1;
		@(negedge clk_sys);
		check_sd(dropped);
		sd_ack = 1'b0;
	endtask

	// Walk all sectors, lba in order
	task automatic run_sectors(input logic load);
		sd_req_t exp;
		for (int i = 0; i < SAVE_SECTORS; i++) begin
			while (!(sd_req.rd || sd_req.wr))
				@(negedge clk_sys);
			exp.lba = 7'(i);
			exp.rd  = load;
			exp.wr  = ~load;
			check_sd(exp);
			check_flag("bk_loading_o", bk_loading, load);
			exp.rd = 1'b0;
			exp.wr = 1'b0;
			ack_sector(exp);
		end
		while (bk_busy)
			@(negedge clk_sys);
		check_sd(exp);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic check_reset_state();
		sd_req_t idle;
		idle = '0;
		check_flag("region_set_o", region_set, 1'b0);
		check_flag("cheat_valid_o", cheat_valid, 1'b0);
		check_sd(idle);
		check_flag("bk_busy_o", bk_busy, 1'b0);
		check_flag("bk_loading_o", bk_loading, 1'b0);
		check_flag("sav_pending_o", sav_pending, 1'b0);
		check_flag("cart_o.hdr_ready", cart.hdr_ready, 1'b0);
	endtask

	task automatic test_priority();
		for (int p = 0; p < 4; p++) begin
			region_cfg.mode = AUTO_HEADER;
			region_cfg.prio = region_prio_e'(p);
			// All three letters, then J and E, then no letters
			run_header(8'h01, {"J", "U"}, {8'h20, "E"}, EXP_ALL[p], 1'b1);
			run_header(8'h01, {"J", 8'h20}, {8'h20, "E"}, EXP_JE[p], 1'b1);
			run_header(8'h01, 16'h2020, 16'h2020, EXP_NONE[p], 1'b1);
		end
	endtask

	task automatic test_header_codes();
		region_cfg.mode = AUTO_HEADER;
		region_cfg.prio = PRIO_JUE;
		// "4" is U only, "8" is E only, "C" is U and E
		run_header(8'h01, {8'h20, "4"}, 16'h2020, REGION_US, 1'b1);
		check_cart(cart_after(1'b0, 3'b010));
		run_header(8'h01, {8'h20, "8"}, 16'h2020, REGION_EU, 1'b1);
		check_cart(cart_after(1'b0, 3'b001));
		run_header(8'h01, {8'h20, "C"}, 16'h2020, REGION_US, 1'b1);
		check_cart(cart_after(1'b0, 3'b011));
		region_cfg.mode = AUTO_FILE_EXT;
		run_header(8'h41, {8'h20, "J"}, 16'h2020, REGION_US, 1'b1);
		check_cart(cart_after(1'b0, 3'b100));
		// SMS image keeps the previous region
		region_cfg.mode = AUTO_HEADER;
		run_header(8'h02, {8'h20, "E"}, 16'h2020, REGION_US, 1'b0);
		check_cart(cart_after(1'b1, 3'b001));
	endtask

	task automatic test_keys();
		key.code    = KEY_F3;
		key.pressed = 1'b1;
		key.toggle  = ~key.toggle;
		@(negedge clk_sys);
		check_region(REGION_EU, 1'b1);
		key.pressed = 1'b0;
		key.toggle  = ~key.toggle;
		@(negedge clk_sys);
		check_region(REGION_EU, 1'b0);
		key.code    = KEY_F1;
		key.pressed = 1'b1;
		key.toggle  = ~key.toggle;
		@(negedge clk_sys);
		check_region(REGION_JP, 1'b1);
	endtask

	task automatic test_cheat();
		logic [15:0] words [CHEAT_WORDS];
		cheat_code_t exp;
		int          pulses;
		for (int i = 0; i < CHEAT_WORDS; i++)
			words[i] = 16'($random(seed));
		exp = {words[1], words[0], words[3], words[2], words[5], words[4], words[7], words[6]};
		pulses = 0;
		start_download(8'hFF);
		for (int i = 0; i < CHEAT_WORDS; i++) begin
			write_beat(25'h40 + 25'(2 * i), words[i]);
			if (cheat_valid)
				pulses++;
		end
		check_flag("cheat_valid_o", cheat_valid, 1'b1);
		check_cheat(exp);
		repeat (3) begin
			@(negedge clk_sys);
			if (cheat_valid)
				pulses++;
		end
		end_download();
		if (pulses != 1) begin
			$display("[ERROR] cheat_valid_o pulses: got %h expected %h", pulses, 1);
			abort_run();
		end
	endtask

	task automatic test_backup();
		// Writable nonempty save image mounted during the cartridge download
		img_mounted = 1'b1;
		img_size_nz = 1'b1;
		start_download(8'h01);
		end_download();
		img_mounted = 1'b0;
		img_size_nz = 1'b0;
		run_sectors(1'b1);
		check_flag("bk_loading_o", bk_loading, 1'b0);
		check_flag("bk_busy_o", bk_busy, 1'b0);
		bk_save = 1'b1;
		run_sectors(1'b0);
		bk_save = 1'b0;
		check_flag("bk_loading_o", bk_loading, 1'b0);
		check_flag("sav_pending_o", sav_pending, 1'b0);
		bk_change = 1'b1;
		@(negedge clk_sys);
		check_flag("sav_pending_o", sav_pending, 1'b1);
		bk_change  = 1'b0;
		autosave   = 1'b1;
		osd_status = 1'b1;
		run_sectors(1'b0);
		check_flag("sav_pending_o", sav_pending, 1'b0);
		osd_status = 1'b0;
		autosave   = 1'b0;
	endtask

	initial begin
		seed         = 32'h33f1;
		sys_reset    = 1'b1;
		ioctl        = '0;
		key          = '0;
		region_cfg   = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		autosave     = 1'b0;
		osd_status   = 1'b0;
		bk_change    = 1'b0;
		sd_ack       = 1'b0;
		repeat (8) @(negedge clk_sys);
		sys_reset = 1'b0;
		check_reset_state();
		test_priority();
		test_header_codes();
		test_keys();
		test_cheat();
		test_backup();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hw/md_loader_pkg.sv
hw/cart_header_scan.sv
hw/region_select.sv
hw/cheat_code_loader.sv
hw/backup_ram_seq.sv
hw/md_loader_top.sv
test/tb_md_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the loader testbench with Verilator.
# The exit status is nonzero unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --top-module tb_md_loader -f build.f -o sim_md_loader \
	> "$LOG" 2>&1 \
	&& ./obj_dir/sim_md_loader >> "$LOG" 2>&1

cat "$LOG"

grep -q "^TEST PASSED$" "$LOG" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
